// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// byte address and instruction / memory word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// line geometry
	localparam int unsigned WORD_BYTES = 4;
	localparam int unsigned LINE_WORDS = 4;
	localparam int unsigned LINE_BYTES = WORD_BYTES * LINE_WORDS;
	localparam int unsigned NUM_WAYS   = 4;

	// address fields below the set index
	// byte within a word
	localparam int unsigned BYTE_OFF_W = $clog2(WORD_BYTES);
	// byte within a line, index starts right above
	localparam int unsigned LINE_OFF_W = $clog2(LINE_BYTES);
	// word within a line
	localparam int unsigned WORD_SEL_W = $clog2(LINE_WORDS);

	// word 0 sits in the low lane
	typedef word_t [LINE_WORDS-1:0] line_t;

	typedef logic [NUM_WAYS-1:0] way_oh_t;

	// read burst request, len is beats minus one
	typedef struct packed {
		addr_t      addr;
		logic [7:0] len;
	} mem_ar_t;

	// one read beat
	typedef struct packed {
		word_t data;
		logic  last;
	} mem_r_t;

	// single word store
	typedef struct packed {
		addr_t addr;
		word_t data;
	} store_t;

endpackage

`default_nettype wire

// ==== icache_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_sram import icache_pkg::*; #(
	parameter type         T     = line_t,
	parameter int unsigned DEPTH = 64
) (
	input  wire logic                     clk,
	input  wire logic                     en,
	input  wire logic [LINE_WORDS-1:0]    we,
	input  wire logic [$clog2(DEPTH)-1:0] addr,
	input  wire T                         wdata,
	output T                              rdata
);

	// one write lane per word of the entry
	localparam int unsigned DATA_W = $bits(T);
	localparam int unsigned LANE_W = DATA_W / LINE_WORDS;

	logic [DATA_W-1:0] mem_q [DEPTH];
	logic [DATA_W-1:0] wdata_bits;
	logic [DATA_W-1:0] rdata_q;

	assign wdata_bits = wdata;

	always_ff @(posedge clk) begin
		if (en) begin
			if (|we) begin
				// partial write, only enabled lanes change
				for (int i = 0; i < LINE_WORDS; i++) begin
					if (we[i]) begin
						mem_q[addr][i*LANE_W +: LANE_W] <= wdata_bits[i*LANE_W +: LANE_W];
					end
				end
			end else begin
				// read port, data valid the cycle after en
				rdata_q <= mem_q[addr];
			end
		end
	end

	assign rdata = rdata_q;

endmodule

`default_nettype wire

// ==== icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array import icache_pkg::*; #(
	parameter int unsigned NUM_SETS = 64
) (
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire addr_t   lookup_addr,
	output way_oh_t      hit_way,
	input  wire logic    fill_en,
	input  wire way_oh_t fill_way,
	input  wire addr_t   fill_addr,
	input  wire logic    st_valid,
	input  wire store_t  st
);

	localparam int unsigned IDX_W = $clog2(NUM_SETS);
	localparam int unsigned TAG_W = 32 - IDX_W - LINE_OFF_W;

	// tag registers per way and set, compare is combinational
	logic [TAG_W-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
	logic [NUM_WAYS-1:0] valid_q [NUM_SETS];

	logic [IDX_W-1:0] lk_idx;
	logic [TAG_W-1:0] lk_tag;
	logic [IDX_W-1:0] fill_idx;
	logic [TAG_W-1:0] fill_tag;
	logic [IDX_W-1:0] st_idx;
	logic [TAG_W-1:0] st_tag;
	logic             st_hits_fill;

	assign lk_idx   = lookup_addr[LINE_OFF_W +: IDX_W];
	assign lk_tag   = lookup_addr[31 -: TAG_W];
	assign fill_idx = fill_addr[LINE_OFF_W +: IDX_W];
	assign fill_tag = fill_addr[31 -: TAG_W];
	assign st_idx   = st.addr[LINE_OFF_W +: IDX_W];
	assign st_tag   = st.addr[31 -: TAG_W];

	// store lands on the very line being installed
	assign st_hits_fill = st_valid && fill_en && (st_idx == fill_idx) && (st_tag == fill_tag);

	// all ways compared in parallel
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_way[w] = valid_q[lk_idx][w] && (tag_q[w][lk_idx] == lk_tag);
		end
	end

	// tag install on the last refill beat
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill_en && fill_way[w]) begin
				tag_q[w][fill_idx] <= fill_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				// new line is born stale if a store hits it at the same edge
				if (fill_en && fill_way[w]) begin
					valid_q[fill_idx][w] <= !st_hits_fill;
				end
				// store invalidates a matching copy, unless that entry is being replaced
				if (st_valid && (tag_q[w][st_idx] == st_tag) &&
				    !(fill_en && fill_way[w] && (fill_idx == st_idx))) begin
					valid_q[st_idx][w] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill import icache_pkg::*; #(
	parameter int unsigned NUM_SETS = 64
) (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  miss,
	input  wire addr_t                 miss_addr,
	output logic                       ar_valid,
	input  wire logic                  ar_ready,
	output mem_ar_t                    ar,
	input  wire logic                  r_valid,
	input  wire mem_r_t                r,
	output logic                       busy,
	output logic                       fill_en,
	output way_oh_t                    fill_way,
	output addr_t                      fill_addr,
	output logic [LINE_WORDS-1:0]      data_we,
	output way_oh_t                    data_way,
	output word_t                      data_word
);

	localparam int unsigned IDX_W = $clog2(NUM_SETS);
	localparam int unsigned TAG_W = 32 - IDX_W - LINE_OFF_W;

	typedef enum logic {
		ST_IDLE,
		ST_FILL
	} state_e;

	state_e state_q;

	// line under refill, captured on the address handshake
	logic [TAG_W-1:0] line_tag_q;
	logic [IDX_W-1:0] line_idx_q;

	// one-hot word lane of the next beat
	logic [LINE_WORDS-1:0] beat_q;
	// one-hot replacement way
	way_oh_t               victim_q;

	logic ar_fire;
	logic beat_fire;

	// request only while idle, the held request keeps it high
	assign ar_valid  = (state_q == ST_IDLE) && miss;
	assign ar.addr   = {miss_addr[31:LINE_OFF_W], LINE_OFF_W'(0)};
	assign ar.len    = 8'(LINE_WORDS - 1);
	assign ar_fire   = ar_valid && ar_ready;

	// r_ready is tied high, any valid beat is taken
	assign beat_fire = (state_q == ST_FILL) && r_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= ST_IDLE;
			beat_q   <= LINE_WORDS'(1);
			victim_q <= way_oh_t'(1);
		end else begin
			case (state_q)
				ST_IDLE: begin
					// pointer keeps turning while nothing is filled
					victim_q <= {victim_q[NUM_WAYS-2:0], victim_q[NUM_WAYS-1]};
					if (ar_fire) begin
						state_q <= ST_FILL;
						beat_q  <= LINE_WORDS'(1);
					end
				end
				ST_FILL: begin
					if (beat_fire) begin
						beat_q <= {beat_q[LINE_WORDS-2:0], beat_q[LINE_WORDS-1]};
						if (r.last) begin
							state_q <= ST_IDLE;
						end
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			line_tag_q <= miss_addr[31 -: TAG_W];
			line_idx_q <= miss_addr[LINE_OFF_W +: IDX_W];
		end
	end

	assign busy = (state_q == ST_FILL);

	// tag goes in with the final beat
	assign fill_en   = beat_fire && r.last;
	assign fill_way  = victim_q;
	assign fill_addr = {line_tag_q, line_idx_q, LINE_OFF_W'(0)};

	// each beat writes only its own word lane of the victim line
	assign data_we   = beat_fire ? beat_q : '0;
	assign data_way  = victim_q;
	assign data_word = r.data;

endmodule

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache import icache_pkg::*; #(
	parameter int unsigned NUM_SETS = 64
) (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   req_valid,
	input  wire addr_t  req_addr,
	input  wire logic   flush,
	output logic        rsp_valid,
	output word_t       rsp_inst,
	output logic        ar_valid,
	input  wire logic   ar_ready,
	output mem_ar_t     ar,
	input  wire logic   r_valid,
	input  wire mem_r_t r,
	input  wire logic   st_valid,
	input  wire store_t st
);

	localparam int unsigned IDX_W = $clog2(NUM_SETS);

	way_oh_t               hit_way;
	logic                  busy;
	logic                  hit;
	logic                  miss;

	logic                  fill_en;
	way_oh_t               fill_way;
	addr_t                 fill_addr;
	logic [LINE_WORDS-1:0] data_we;
	way_oh_t               data_way;
	word_t                 data_word;

	// data RAM side
	logic [IDX_W-1:0]      ram_addr;
	logic [NUM_WAYS-1:0]   ram_en;
	logic [LINE_WORDS-1:0] ram_we    [NUM_WAYS];
	line_t                 ram_rdata [NUM_WAYS];
	line_t                 fill_line;
	line_t                 line_sel;

	// response register
	logic                  rsp_valid_q;
	way_oh_t               way_q;
	logic [WORD_SEL_W-1:0] off_q;

	// lookups only happen while no refill is running
	assign hit  = req_valid && !busy && (hit_way != '0);
	assign miss = req_valid && !busy && (hit_way == '0);

	icache_tag_array #(
		.NUM_SETS (NUM_SETS)
	) i_tag_array (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (req_addr),
		.hit_way     (hit_way),
		.fill_en     (fill_en),
		.fill_way    (fill_way),
		.fill_addr   (fill_addr),
		.st_valid    (st_valid),
		.st          (st)
	);

	icache_refill #(
		.NUM_SETS (NUM_SETS)
	) i_refill (
		.clk       (clk),
		.rst       (rst),
		.miss      (miss),
		.miss_addr (req_addr),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.ar        (ar),
		.r_valid   (r_valid),
		.r         (r),
		.busy      (busy),
		.fill_en   (fill_en),
		.fill_way  (fill_way),
		.fill_addr (fill_addr),
		.data_we   (data_we),
		.data_way  (data_way),
		.data_word (data_word)
	);

	// fill index during a refill, request index otherwise
	assign ram_addr  = busy ? fill_addr[LINE_OFF_W +: IDX_W] : req_addr[LINE_OFF_W +: IDX_W];
	// beat word copied to every lane, the lane enable picks the slot
	assign fill_line = {LINE_WORDS{data_word}};

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		assign ram_we[w] = data_way[w] ? data_we : '0;
		// write a beat while filling, read the hit way on lookup
		assign ram_en[w] = busy ? (ram_we[w] != '0) : (req_valid && hit_way[w]);

		icache_sram #(
			.T     (line_t),
			.DEPTH (NUM_SETS)
		) i_data_ram (
			.clk   (clk),
			.en    (ram_en[w]),
			.we    (ram_we[w]),
			.addr  (ram_addr),
			.wdata (fill_line),
			.rdata (ram_rdata[w])
		);
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= hit;
		end
	end

	// way and word offset follow the RAM read by one cycle
	always_ff @(posedge clk) begin
		if (hit) begin
			way_q <= hit_way;
			off_q <= req_addr[BYTE_OFF_W +: WORD_SEL_W];
		end
	end

	// one-hot way mux
	always_comb begin
		line_sel = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way_q[w]) begin
				line_sel = line_sel | ram_rdata[w];
			end
		end
	end

	// a flush in the response cycle also drops the response
	assign rsp_valid = rsp_valid_q && !flush;
	assign rsp_inst  = line_sel[off_q];

endmodule

`default_nettype wire

// ==== icache_burst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_burst_mem import icache_pkg::*; #(
	parameter int unsigned WORDS = 1024,
	parameter int unsigned LAT   = 2
) (
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    ar_valid,
	output logic         ar_ready,
	input  wire mem_ar_t ar,
	output logic         r_valid,
	output mem_r_t       r,
	input  wire logic    st_valid,
	input  wire store_t  st
);

	localparam int unsigned PTR_W  = $clog2(WORDS);
	// keep at least one bit when there is no wait
	localparam int unsigned WAIT_W = (LAT > 0) ? $clog2(LAT + 1) : 1;

	word_t             mem_q [WORDS];

	logic              busy_q;
	logic [PTR_W-1:0]  ptr_q;
	logic [7:0]        left_q;
	logic [WAIT_W-1:0] wait_q;
	logic              r_valid_q;
	mem_r_t            r_q;

	// one burst at a time
	assign ar_ready = !busy_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q    <= 1'b0;
			r_valid_q <= 1'b0;
		end else begin
			r_valid_q <= 1'b0;
			if (ar_valid && ar_ready) begin
				busy_q <= 1'b1;
				ptr_q  <= ar.addr[BYTE_OFF_W +: PTR_W];
				left_q <= ar.len;
				wait_q <= WAIT_W'(LAT);
			end else if (busy_q) begin
				if (wait_q != '0) begin
					wait_q <= wait_q - 1'b1;
				end else begin
					// emit one beat, then restart the wait
					r_valid_q <= 1'b1;
					r_q.data  <= mem_q[ptr_q];
					r_q.last  <= (left_q == '0);
					ptr_q     <= ptr_q + 1'b1;
					left_q    <= left_q - 1'b1;
					wait_q    <= WAIT_W'(LAT);
					if (left_q == '0) begin
						busy_q <= 1'b0;
					end
				end
			end
		end
	end

	// memory comes up zero, stores overwrite one word
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < WORDS; i++) begin
				mem_q[i] <= '0;
			end
		end else if (st_valid) begin
			mem_q[st.addr[BYTE_OFF_W +: PTR_W]] <= st.data;
		end
	end

	assign r_valid = r_valid_q;
	assign r       = r_q;

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
	parameter int unsigned NUM_SETS  = 64,
	parameter int unsigned MEM_WORDS = 1024,
	parameter int unsigned MEM_LAT   = 2
) (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   req_valid,
	input  wire addr_t  req_addr,
	input  wire logic   flush,
	output logic        rsp_valid,
	output word_t       rsp_inst,
	input  wire logic   st_valid,
	input  wire store_t st
);

	// refill channels between cache and memory
	logic    ar_valid;
	logic    ar_ready;
	mem_ar_t ar;
	logic    r_valid;
	mem_r_t  r;

	icache #(
		.NUM_SETS (NUM_SETS)
	) i_icache (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.flush     (flush),
		.rsp_valid (rsp_valid),
		.rsp_inst  (rsp_inst),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.ar        (ar),
		.r_valid   (r_valid),
		.r         (r),
		.st_valid  (st_valid),
		.st        (st)
	);

	// stores reach memory and the tag array in the same cycle
	icache_burst_mem #(
		.WORDS (MEM_WORDS),
		.LAT   (MEM_LAT)
	) i_mem (
		.clk      (clk),
		.rst      (rst),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.ar       (ar),
		.r_valid  (r_valid),
		.r        (r),
		.st_valid (st_valid),
		.st       (st)
	);

endmodule

`default_nettype wire

// ==== icache_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_assertions (
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic rsp_valid,
	input wire logic ar_valid,
	input wire logic ar_ready
);

	// burst request stays up until memory takes it
	property ar_held;
		@(posedge clk) disable iff (rst)
		(ar_valid && !ar_ready) |=> ar_valid;
	endproperty

	// response is a single-cycle pulse
	property rsp_pulse;
		@(posedge clk) disable iff (rst)
		rsp_valid |=> !rsp_valid;
	endproperty

	// flush clears the response register
	property rsp_after_flush;
		@(posedge clk) disable iff (rst)
		flush |=> !rsp_valid;
	endproperty

	a_ar_held: assert property (ar_held)
		else $error("ar_valid dropped before ar_ready");
	a_rsp_pulse: assert property (rsp_pulse)
		else $error("rsp_valid high for two cycles");
	a_rsp_after_flush: assert property (rsp_after_flush)
		else $error("rsp_valid right after a flush cycle");

endmodule

bind icache icache_assertions i_assertions (
	.clk       (clk),
	.rst       (rst),
	.flush     (flush),
	.rsp_valid (rsp_valid),
	.ar_valid  (ar_valid),
	.ar_ready  (ar_ready)
);

`default_nettype wire

// ==== tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

	// cache geometry and memory timing for this run
	localparam int unsigned NUM_SETS  = 64;
	// big enough that the conflict lines of one set do not alias in memory
	localparam int unsigned MEM_WORDS = 2048;
	localparam int unsigned MEM_LAT   = 2;

	logic   clk = 1'b0;
	logic   rst;
	logic   req_valid;
	addr_t  req_addr;
	logic   flush;
	logic   rsp_valid;
	word_t  rsp_inst;
	logic   st_valid;
	store_t st;

	// one entry per test line of the data file
	string op_q   [$];
	addr_t addr_q [$];
	word_t val_q  [$];
	string name_q [$];

	int unsigned cycle_limit = 0;
	int unsigned cycle_count = 0;
	integer      seed;

	icache_top #(
		.NUM_SETS  (NUM_SETS),
		.MEM_WORDS (MEM_WORDS),
		.MEM_LAT   (MEM_LAT)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.flush     (flush),
		.rsp_valid (rsp_valid),
		.rsp_inst  (rsp_inst),
		.st_valid  (st_valid),
		.st        (st)
	);

	always #5 clk = ~clk;

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %08h actual %08h", name, expected, actual);
			abort_run();
		end
	endtask

	// runaway guard sized from the number of tests
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	task automatic load_tests();
		int    fd;
		int    n;
		string line;
		string op;
		string name;
		addr_t a;
		word_t v;
		fd = $fopen("icache_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file icache_tests.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// skip blank and comment lines
			if (line.len() == 0 || line.substr(0, 0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %h %h %s", op, a, v, name);
			if (n == 4) begin
				op_q.push_back(op);
				addr_q.push_back(a);
				val_q.push_back(v);
				name_q.push_back(name);
			end
		end
		$fclose(fd);
		if (op_q.size() == 0) begin
			$display("the test file holds no tests");
			abort_run();
		end
	endtask

	task automatic idle_gap();
		int gap;
		gap = {$random(seed)} % 4;
		repeat (gap) @(posedge clk);
	endtask

	// one-cycle store whose memory write and tag invalidation land at the next edge
	task automatic store_word(input addr_t a, input word_t d);
		@(posedge clk);
		st_valid <= 1'b1;
		st.addr  <= a;
		st.data  <= d;
		@(posedge clk);
		st_valid <= 1'b0;
	endtask

	// lat counts edges from the request to the response
	task automatic fetch_word(input addr_t a, output word_t inst, output int lat);
		@(posedge clk);
		req_valid <= 1'b1;
		req_addr  <= a;
		lat = 0;
		@(negedge clk);
		while (!rsp_valid) begin
			@(posedge clk);
			lat++;
			@(negedge clk);
		end
		inst = rsp_inst;
		// held request looks up again in the response cycle
		// so its repeat answer is cancelled
		@(posedge clk);
		req_valid <= 1'b0;
		flush     <= 1'b1;
		@(posedge clk);
		flush     <= 1'b0;
	endtask

	task automatic run_fetch(input addr_t a, input word_t expected, input string name,
	                         input logic want_hit);
		word_t inst;
		int    lat;
		fetch_word(a, inst, lat);
		check_equal(name, expected, inst);
		// a line loaded by the previous fetch answers one cycle later
		if (want_hit) begin
			check_equal({name, "_latency"}, 1, lat);
		end
	endtask

	// hit lookup, then flush in the response cycle while the request still looks up
	task automatic flush_hit(input addr_t a, input string name);
		@(posedge clk);
		req_valid <= 1'b1;
		req_addr  <= a;
		@(posedge clk);
		flush     <= 1'b1;
		@(negedge clk);
		check_equal({name, "_rsp_in_flush"}, 0, rsp_valid);
		// the second lookup hit too, only the cleared register hides it
		@(posedge clk);
		req_valid <= 1'b0;
		flush     <= 1'b0;
		@(negedge clk);
		check_equal({name, "_rsp_after_flush"}, 0, rsp_valid);
	endtask

	initial begin
		addr_t line_now;
		addr_t last_line;
		logic  last_fetch;
		logic  want_hit;
		seed = 97270;
		rst       <= 1'b1;
		req_valid <= 1'b0;
		req_addr  <= '0;
		flush     <= 1'b0;
		st_valid  <= 1'b0;
		st        <= '0;
		load_tests();
		cycle_limit = op_q.size() * (4 * (MEM_LAT + 2) + 20);
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		last_fetch = 1'b0;
		last_line  = '0;
		for (int i = 0; i < op_q.size(); i++) begin
			line_now = addr_q[i] >> LINE_OFF_W;
			want_hit = last_fetch && (line_now == last_line);
			if (op_q[i] == "S") begin
				store_word(addr_q[i], val_q[i]);
				last_fetch = 1'b0;
			end else if (op_q[i] == "F") begin
				run_fetch(addr_q[i], val_q[i], name_q[i], want_hit);
				last_fetch = 1'b1;
				last_line  = line_now;
			end else if (op_q[i] == "X") begin
				flush_hit(addr_q[i], name_q[i]);
				// reissue after the cancelled response
				run_fetch(addr_q[i], val_q[i], name_q[i], want_hit);
				last_fetch = 1'b1;
				last_line  = line_now;
			end else begin
				$display("unknown operation %s in test %s", op_q[i], name_q[i]);
				abort_run();
			end
			idle_gap();
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== icache_tests.txt ====
# op addr value name
# op: S store value to addr, F fetch addr expect value, X flush a hit then refetch expect value
F 00000100 00000000 cold_line_zero
S 00000200 11110000 store_w0
S 00000204 11110001 store_w1
S 00000208 11110002 store_w2
S 0000020C 11110003 store_w3
F 00000200 11110000 line_w0_miss
F 00000204 11110001 line_w1_hit
F 00000208 11110002 line_w2_hit
F 0000020C 11110003 line_w3_hit
F 00000100 00000000 repeat_cold_line
F 00000100 00000000 repeat_cold_hit
S 00000040 A0000000 conflict_store_0
F 00000040 A0000000 conflict_fetch_0
S 00000444 A0000001 conflict_store_1
F 00000444 A0000001 conflict_fetch_1
S 00000848 A0000002 conflict_store_2
F 00000848 A0000002 conflict_fetch_2
S 00000C4C A0000003 conflict_store_3
F 00000C4C A0000003 conflict_fetch_3
S 00001040 A0000004 conflict_store_4
F 00001040 A0000004 conflict_fetch_4
F 00000040 A0000000 conflict_refetch_0
F 00000444 A0000001 conflict_refetch_1
F 00000848 A0000002 conflict_refetch_2
F 00000C4C A0000003 conflict_refetch_3
F 00001040 A0000004 conflict_refetch_4
F 00000204 11110001 cached_before_store
S 00000204 22220001 store_over_cached
F 00000204 22220001 fetch_after_store
F 00000208 11110002 neighbor_after_refill
X 00000208 11110002 flush_after_hit
F 0000020C 11110003 fetch_after_flush

// ==== vlog.f ====
icache_pkg.sv
icache_sram.sv
icache_tag_array.sv
icache_refill.sv
icache.sv
icache_burst_mem.sv
icache_top.sv
icache_assertions.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  # design, in compile order
  - icache_pkg.sv
  - icache_sram.sv
  - icache_tag_array.sv
  - icache_refill.sv
  - icache.sv
  - icache_burst_mem.sv
  - icache_top.sv
  # testbench
  - target: test
    files:
      - icache_assertions.sv
      - tb_icache.sv
